//--- include/icache_params.svh
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// byte address width of the fetch and memory side.
`define ICACHE_ADDR_W 32

// number of direct-mapped lines, a power of two.
`define ICACHE_LINES 16

// 32-bit words per line, a power of two.
`define ICACHE_LINE_WORDS 4

`endif

//--- hw/icache_pkg.sv
`include "icache_params.svh"

package icache_pkg;

  localparam int unsigned ICACHE_OFF_W = $clog2(`ICACHE_LINE_WORDS);
  localparam int unsigned ICACHE_IDX_W = $clog2(`ICACHE_LINES);
  localparam int unsigned ICACHE_TAG_W = `ICACHE_ADDR_W - ICACHE_IDX_W - ICACHE_OFF_W - 2;

  // fetch address, either raw or split into cache fields.
  typedef union packed {
    logic [`ICACHE_ADDR_W-1:0] raw;
    struct packed {
      logic [ICACHE_TAG_W-1:0] tag;
      logic [ICACHE_IDX_W-1:0] index;
      logic [ICACHE_OFF_W-1:0] offset;
      logic [1:0]              byte_off;
    } fields;
  } icache_addr_u;

  typedef enum logic [1:0] {
    LOOKUP,
    RESPOND,
    REFILL,
    ALLOCATE
  } icache_state_e;

endpackage

//--- hw/icache_controller.sv
`timescale 1ns/1ps

module icache_controller import icache_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic if_req_i,
  input  logic hit_i,
  input  logic refill_done_i,
  output logic if_ack_o,
  output logic refill_start_o,
  output logic tag_we_o
);

  icache_state_e state_q;
  icache_state_e state_d;
  logic          ack_d;

  always_comb begin
    state_d = state_q;
    ack_d   = 1'b0;
    unique case (state_q)
      LOOKUP: begin
        if (if_req_i) begin
          if (hit_i) begin
            state_d = RESPOND;
            ack_d   = 1'b1;
          end else begin
            state_d = REFILL;
          end
        end
      end
      // the request is not looked at while the ack is out.
      RESPOND: begin
        state_d = LOOKUP;
      end
      REFILL: begin
        if (refill_done_i) begin
          state_d = ALLOCATE;
        end
      end
      ALLOCATE: begin
        state_d = LOOKUP;
      end
    endcase
  end

  // start the engine on the same edge that moves us to REFILL.
  assign refill_start_o = (state_q == LOOKUP) && if_req_i && !hit_i;
  assign tag_we_o       = (state_q == ALLOCATE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= LOOKUP;
      if_ack_o <= 1'b0;
    end else begin
      state_q  <= state_d;
      if_ack_o <= ack_d;
    end
  end

  // requester gets exactly one ack cycle per request.
  property p_ack_single;
    @(posedge clk_i) disable iff (!rst_ni)
      if_ack_o |=> !if_ack_o;
  endproperty
  a_ack_single: assert property (p_ack_single)
    else $error("if_ack_o held high for two cycles.");

  // the engine only reports a finished line while the FSM waits for it.
  property p_done_in_refill;
    @(posedge clk_i) disable iff (!rst_ni)
      refill_done_i |-> (state_q == REFILL);
  endproperty
  a_done_in_refill: assert property (p_done_in_refill)
    else $error("refill_done_i seen outside REFILL.");

endmodule

//--- hw/icache_tag_array.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module icache_tag_array import icache_pkg::*; (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  icache_addr_u addr_i,
  input  logic         tag_we_i,
  input  logic         flush_i,
  output logic         hit_o
);

  logic [`ICACHE_LINES-1:0] valid_q;
  logic [ICACHE_TAG_W-1:0]  tag_q [`ICACHE_LINES];

  logic [ICACHE_IDX_W-1:0]  idx;
  logic [ICACHE_TAG_W-1:0]  stored_tag;

  assign idx        = addr_i.fields.index;
  assign stored_tag = tag_q[idx];

  assign hit_o = valid_q[idx] && (stored_tag == addr_i.fields.tag);

  // flush only comes while the fetch side is idle.
  // an allocate wins over it anyway so a fresh line is never dropped.
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (tag_we_i) begin
      valid_q[idx] <= 1'b1;
    end else if (flush_i) begin
      valid_q <= '0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (tag_we_i) begin
      tag_q[idx] <= addr_i.fields.tag;
    end
  end

endmodule

//--- hw/icache_data_array.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module icache_data_array import icache_pkg::*; (
  input  logic                    clk_i,
  input  icache_addr_u            addr_i,
  input  logic                    fill_we_i,
  input  logic [ICACHE_OFF_W-1:0] fill_word_i,
  input  logic [31:0]             fill_data_i,
  output logic [31:0]             rdata_o
);

  localparam int unsigned WordsTotal = `ICACHE_LINES * `ICACHE_LINE_WORDS;
  localparam int unsigned WordAddrW  = ICACHE_IDX_W + ICACHE_OFF_W;

  logic [31:0]          mem_q [WordsTotal];
  logic [WordAddrW-1:0] wr_addr;
  logic [WordAddrW-1:0] rd_addr;

  // fills go to the line of the pending fetch, word by word.
  assign wr_addr = {addr_i.fields.index, fill_word_i};
  assign rd_addr = {addr_i.fields.index, addr_i.fields.offset};

  always_ff @(posedge clk_i) begin
    if (fill_we_i) begin
      mem_q[wr_addr] <= fill_data_i;
    end
  end

  // read is asynchronous; the ack register gives the timing.
  assign rdata_o = mem_q[rd_addr];

endmodule

//--- hw/icache_refill.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module icache_refill import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      start_i,
  input  icache_addr_u              line_addr_i,
  output logic                      done_o,
  output logic                      fill_we_o,
  output logic [ICACHE_OFF_W-1:0]   fill_word_o,
  output logic [31:0]               fill_data_o,
  output logic                      m_arvalid_o,
  output logic [`ICACHE_ADDR_W-1:0] m_araddr_o,
  output logic                      m_rready_o,
  input  logic                      m_arready_i,
  input  logic                      m_rvalid_i,
  input  logic [31:0]               m_rdata_i
);

  logic [ICACHE_OFF_W-1:0] word_q;
  icache_addr_u            rd_addr;
  logic                    ar_fire;
  logic                    r_fire;
  logic                    last_word;

  assign ar_fire   = m_arvalid_o && m_arready_i;
  assign r_fire    = m_rvalid_i && m_rready_o;
  assign last_word = (word_q == ICACHE_OFF_W'(`ICACHE_LINE_WORDS - 1));

  always_comb begin
    rd_addr                 = line_addr_i;
    rd_addr.fields.offset   = word_q;
    rd_addr.fields.byte_off = 2'b00;
  end

  assign m_araddr_o = rd_addr.raw;

  // each R beat becomes one fill write.
  assign fill_we_o   = r_fire;
  assign fill_word_o = word_q;
  assign fill_data_o = m_rdata_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      word_q      <= '0;
      m_arvalid_o <= 1'b0;
      m_rready_o  <= 1'b0;
      done_o      <= 1'b0;
    end else begin
      done_o <= 1'b0;
      if (start_i) begin
        word_q      <= '0;
        m_arvalid_o <= 1'b1;
      end else if (ar_fire) begin
        m_arvalid_o <= 1'b0;
        m_rready_o  <= 1'b1;
      end else if (r_fire) begin
        m_rready_o <= 1'b0;
        if (last_word) begin
          done_o <= 1'b1;
        end else begin
          word_q      <= word_q + 1'b1;
          m_arvalid_o <= 1'b1;
        end
      end
    end
  end

  // AR payload holds until the slave takes it.
  property p_ar_stable;
    @(posedge clk_i) disable iff (!rst_ni)
      m_arvalid_o && !m_arready_i |=> m_arvalid_o && $stable(m_araddr_o);
  endproperty
  a_ar_stable: assert property (p_ar_stable)
    else $error("m_araddr_o changed before the AR handshake.");

endmodule

//--- hw/icache_top.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module icache_top import icache_pkg::*; (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      flush_i,
  input  logic                      if_req_i,
  input  logic [`ICACHE_ADDR_W-1:0] if_addr_i,
  output logic                      if_ack_o,
  output logic [31:0]               if_data_o,
  output logic                      m_arvalid_o,
  output logic [`ICACHE_ADDR_W-1:0] m_araddr_o,
  input  logic                      m_arready_i,
  input  logic                      m_rvalid_i,
  input  logic [31:0]               m_rdata_i,
  output logic                      m_rready_o
);

  icache_addr_u            if_addr;
  logic                    hit;
  logic                    tag_we;
  logic                    refill_start;
  logic                    refill_done;
  logic                    fill_we;
  logic [ICACHE_OFF_W-1:0] fill_word;
  logic [31:0]             fill_data;

  assign if_addr.raw = if_addr_i;

  icache_controller i_icache_controller (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .if_req_i       (if_req_i),
    .hit_i          (hit),
    .refill_done_i  (refill_done),
    .if_ack_o       (if_ack_o),
    .refill_start_o (refill_start),
    .tag_we_o       (tag_we)
  );

  icache_tag_array i_icache_tag_array (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .addr_i   (if_addr),
    .tag_we_i (tag_we),
    .flush_i  (flush_i),
    .hit_o    (hit)
  );

  icache_data_array i_icache_data_array (
    .clk_i       (clk_i),
    .addr_i      (if_addr),
    .fill_we_i   (fill_we),
    .fill_word_i (fill_word),
    .fill_data_i (fill_data),
    .rdata_o     (if_data_o)
  );

  // the held fetch address names the line to refill.
  icache_refill i_icache_refill (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .start_i     (refill_start),
    .line_addr_i (if_addr),
    .done_o      (refill_done),
    .fill_we_o   (fill_we),
    .fill_word_o (fill_word),
    .fill_data_o (fill_data),
    .m_arvalid_o (m_arvalid_o),
    .m_araddr_o  (m_araddr_o),
    .m_rready_o  (m_rready_o),
    .m_arready_i (m_arready_i),
    .m_rvalid_i  (m_rvalid_i),
    .m_rdata_i   (m_rdata_i)
  );

endmodule

//--- testbench/tb_axi_mem.sv
`timescale 1ns/1ps

module tb_axi_mem #(
  parameter logic [31:0] DataXor = 32'h0
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        arvalid_i,
  input  logic [31:0] araddr_i,
  output logic        arready_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  input  logic        rready_i,
  output int          ar_count_o
);

  logic [31:0] lfsr_q;
  logic [31:0] addr_q;
  int          wait_cnt;
  // 0 idle, 1 address delay, 2 address taken, 3 data delay, 4 data taken.
  int          phase;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  // two bits give a stall of 0 to 3 cycles.
  task automatic draw_delay();
    wait_cnt = 0;
    repeat (2) begin
      lfsr_q   = lfsr_next(lfsr_q);
      wait_cnt = wait_cnt * 2 + int'(lfsr_q[0]);
    end
  endtask

  initial begin
    arready_o  = 1'b0;
    rvalid_o   = 1'b0;
    rdata_o    = '0;
    ar_count_o = 0;
    lfsr_q     = 32'h3b03;
    addr_q     = '0;
    wait_cnt   = 0;
    phase      = 0;
    forever begin
      @(negedge clk_i);
      if (!rst_ni) begin
        arready_o = 1'b0;
        rvalid_o  = 1'b0;
        phase     = 0;
      end else begin
        // a ready or valid raised at the last falling edge was taken at the rising one.
        if (phase == 2) begin
          arready_o  = 1'b0;
          ar_count_o = ar_count_o + 1;
          draw_delay();
          phase = 3;
        end else if (phase == 4) begin
          rvalid_o = 1'b0;
          phase    = 0;
        end
        if (phase == 0 && arvalid_i) begin
          draw_delay();
          phase = 1;
        end
        if (phase == 1) begin
          if (wait_cnt > 0) begin
            wait_cnt--;
          end else begin
            arready_o = 1'b1;
            addr_q    = araddr_i;
            phase     = 2;
          end
        end
        if (phase == 3) begin
          if (wait_cnt > 0) begin
            wait_cnt--;
          end else if (rready_i) begin
            rvalid_o = 1'b1;
            rdata_o  = {addr_q[31:2], 2'b00} ^ DataXor;
            phase    = 4;
          end
        end
      end
    end
  end

endmodule

//--- testbench/tb_icache.sv
`timescale 1ns/1ps

`include "icache_params.svh"

module tb_icache;

  localparam logic [31:0] MemXor  = 32'hA5A5_0000;
  localparam int          OffW    = $clog2(`ICACHE_LINE_WORDS);
  localparam int          IdxW    = $clog2(`ICACHE_LINES);
  localparam int          Timeout = 200;

  logic        clk_i;
  logic        rst_ni;
  logic        flush_i;
  logic        if_req_i;
  logic [31:0] if_addr_i;
  logic        if_ack_o;
  logic [31:0] if_data_o;
  logic        m_arvalid_o;
  logic [31:0] m_araddr_o;
  logic        m_arready_i;
  logic        m_rvalid_i;
  logic [31:0] m_rdata_i;
  logic        m_rready_o;
  int          ar_count;
  logic [31:0] lfsr_q;
  logic        shadow_valid [`ICACHE_LINES];
  logic [31:0] shadow_tag [`ICACHE_LINES];
  int          errors;
  int          failed_tests;

  icache_top i_icache_top (.*);

  tb_axi_mem #(.DataXor(MemXor)) i_axi_mem (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .arvalid_i  (m_arvalid_o),
    .araddr_i   (m_araddr_o),
    .arready_o  (m_arready_i),
    .rvalid_o   (m_rvalid_i),
    .rdata_o    (m_rdata_i),
    .rready_i   (m_rready_o),
    .ar_count_o (ar_count)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      val    = {val[30:0], lfsr_q[0]};
    end
  endtask

  function automatic int line_index(input logic [31:0] addr);
    return int'((addr >> (OffW + 2)) & (`ICACHE_LINES - 1));
  endfunction

  // a full line refill is four reads, a resident line none.
  function automatic int shadow_reads(input logic [31:0] addr);
    int idx;
    idx = line_index(addr);
    if (shadow_valid[idx] && shadow_tag[idx] == (addr >> (OffW + IdxW + 2))) begin
      return 0;
    end
    return `ICACHE_LINE_WORDS;
  endfunction

  task automatic fetch_check(input logic [31:0] addr, input int exp_reads);
    int          ar_before;
    int          cycles;
    logic [31:0] exp_data;
    ar_before = ar_count;
    exp_data  = addr ^ MemXor;
    @(negedge clk_i);
    if_req_i  = 1'b1;
    if_addr_i = addr;
    cycles    = 0;
    while (!if_ack_o && cycles < Timeout) begin
      @(negedge clk_i);
      cycles++;
    end
    if_req_i = 1'b0;
    if (!if_ack_o) begin
      $display("no if_ack_o for address %h within %0d cycles", addr, Timeout);
      errors++;
    end else begin
      if (if_data_o !== exp_data) begin
        $display("FAIL t=%0t if_data_o got %h expected %h", $time, if_data_o, exp_data);
        errors++;
      end
      if (ar_count != ar_before + exp_reads) begin
        $display("FAIL t=%0t ar_count got %0d expected %0d", $time, ar_count,
                 ar_before + exp_reads);
        errors++;
      end
      if (exp_reads == 0 && cycles != 1) begin
        $display("FAIL t=%0t if_ack_o latency got %0d expected 1", $time, cycles);
        errors++;
      end
    end
    shadow_valid[line_index(addr)] = 1'b1;
    shadow_tag[line_index(addr)]   = addr >> (OffW + IdxW + 2);
  endtask

  task automatic flush_cache();
    @(negedge clk_i);
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    for (int i = 0; i < `ICACHE_LINES; i++) begin
      shadow_valid[i] = 1'b0;
    end
  endtask

  task automatic report_result(input string name, input int err_before);
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
      failed_tests++;
    end
  endtask

  task automatic cold_miss();
    int err_before;
    err_before = errors;
    fetch_check(32'h0000_1230, `ICACHE_LINE_WORDS);
    report_result("cold miss", err_before);
  endtask

  task automatic line_hit();
    int err_before;
    err_before = errors;
    for (int w = 1; w < `ICACHE_LINE_WORDS; w++) begin
      fetch_check(32'h0000_1230 + w * 4, 0);
    end
    report_result("line hit", err_before);
  endtask

  // same index, other tag, then back.
  task automatic conflict_evict();
    int err_before;
    err_before = errors;
    fetch_check(32'h0000_5638, `ICACHE_LINE_WORDS);
    fetch_check(32'h0000_1230, `ICACHE_LINE_WORDS);
    report_result("conflict eviction", err_before);
  endtask

  task automatic flush_refetch();
    int err_before;
    err_before = errors;
    fetch_check(32'h0000_1230, 0);
    flush_cache();
    fetch_check(32'h0000_1230, `ICACHE_LINE_WORDS);
    report_result("flush", err_before);
  endtask

  // two tags over four indices keep conflicts frequent.
  task automatic random_stress();
    int          err_before;
    logic [31:0] idx;
    logic [31:0] off;
    logic [31:0] sel;
    logic [31:0] addr;
    err_before = errors;
    for (int n = 0; n < 20; n++) begin
      take_bits(2, idx);
      take_bits(2, off);
      take_bits(1, sel);
      addr = ((32'h0000_0100 + sel * 32'h0000_0135) << (OffW + IdxW + 2))
           | (idx << (OffW + 2)) | (off << 2);
      fetch_check(addr, shadow_reads(addr));
    end
    report_result("back-pressure stress", err_before);
  endtask

  initial begin
    rst_ni       = 1'b0;
    flush_i      = 1'b0;
    if_req_i     = 1'b0;
    if_addr_i    = '0;
    lfsr_q       = 32'h3b03;
    errors       = 0;
    failed_tests = 0;
    for (int i = 0; i < `ICACHE_LINES; i++) begin
      shadow_valid[i] = 1'b0;
      shadow_tag[i]   = '0;
    end
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    cold_miss();
    line_hit();
    conflict_evict();
    flush_refetch();
    random_stress();
    $display("tests 5, failed %0d, errors %0d", failed_tests, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+include
hw/icache_pkg.sv
hw/icache_controller.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_refill.sv
hw/icache_top.sv
testbench/tb_axi_mem.sv
testbench/tb_icache.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module tb_icache -o tb_icache
output="$(./obj_dir/tb_icache)"
echo "$output"

grep -qx "TEST PASS" <<< "$output"
